/* verilog/aes_stream_defs.svh */
`ifndef AES_STREAM_DEFS_SVH
`define AES_STREAM_DEFS_SVH

// ============================================================
// Stream and block geometry
// ============================================================

// Width of one stream word
`define AES_WORD_W 32

// Words in one 128-bit AES block
`define AES_NB 4

// Depth of each block RAM, in blocks
`define AES_FIFO_BLOCKS 8

// Block address width, log2 of the RAM depth
`define AES_ADDR_W 3

`endif

/* verilog/aes_stream_pkg.sv */
`include "aes_stream_defs.svh"

package aes_stream_pkg;

        // One word on either stream
        typedef logic [`AES_WORD_W-1:0] word_t;

        // One AES block, also used for the key
        typedef logic [`AES_NB*`AES_WORD_W-1:0] block_t;

        // Address of a block in either RAM
        typedef logic [`AES_ADDR_W-1:0] blk_addr_t;

        // Block count, one bit wider so a full RAM fits
        typedef logic [`AES_ADDR_W:0] blk_cnt_t;

        // Top-level sequencing
        typedef enum logic [1:0] {
                CTRL_IDLE,
                CTRL_RECEIVE,
                CTRL_PROCESS,
                CTRL_SEND
        } ctrl_state_t;

endpackage

/* verilog/block_ram.sv */
`timescale 1ns/10ps
`include "aes_stream_defs.svh"

module block_ram (
        input  logic                               s00_axis_aclk,
        input  logic [`AES_ADDR_W-1:0]             addr,
        input  logic [`AES_NB*`AES_WORD_W-1:0]     wdata,
        input  logic                               we,
        output logic [`AES_NB*`AES_WORD_W-1:0]     rdata
);

        // One entry per 128-bit block
        logic [`AES_NB*`AES_WORD_W-1:0] mem [`AES_FIFO_BLOCKS];

        always_ff @(posedge s00_axis_aclk) begin
                if (we) begin
                        mem[addr] <= wdata;
                end
                // Read of the old contents, one cycle late
                rdata <= mem[addr];
        end

endmodule

/* verilog/axis_block_packer.sv */
`timescale 1ns/10ps
`include "aes_stream_defs.svh"

module axis_block_packer (
        input  logic                       s00_axis_aclk,
        input  logic                       rst_n,
        input  logic                       rx_en,
        input  aes_stream_pkg::word_t      s00_axis_tdata,
        input  logic                       s00_axis_tvalid,
        input  logic                       s00_axis_tlast,
        output logic                       s00_axis_tready,
        output aes_stream_pkg::blk_addr_t  ram_addr,
        output aes_stream_pkg::block_t     ram_wdata,
        output logic                       ram_we,
        output aes_stream_pkg::block_t     key,
        output aes_stream_pkg::blk_cnt_t   blk_cnt,
        output logic                       rx_done
);
        import aes_stream_pkg::*;

        typedef enum logic [1:0] {PK_CMD, PK_KEY, PK_DATA, PK_END} pk_state_t;

        pk_state_t                      state;
        logic [$clog2(`AES_NB)-1:0]     word_cnt;
        blk_cnt_t                       blk_idx;
        block_t                         blk;
        logic                           xfer;
        logic                           word_last;

        assign s00_axis_tready = rx_en && (state != PK_END);
        assign xfer            = s00_axis_tvalid && s00_axis_tready;
        assign word_last       = (word_cnt == `AES_NB - 1);

        // PK_END lasts one cycle, right after the tlast transfer
        assign rx_done = (state == PK_END);

        // The transfer completing a block writes it straight to RAM
        assign ram_wdata = {blk[`AES_WORD_W*(`AES_NB-1)-1:0], s00_axis_tdata};
        assign ram_we    = xfer && (state == PK_DATA) && word_last;
        assign ram_addr  = blk_addr_t'(blk_idx);

        // Payload shift register, first word ends up on top
        always_ff @(posedge s00_axis_aclk) begin
                if (xfer && state == PK_DATA) begin
                        blk <= ram_wdata;
                end
        end

        // ============================================================
        // Frame parser
        // ============================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state    <= PK_CMD;
                        word_cnt <= '0;
                        blk_idx  <= '0;
                        blk_cnt  <= '0;
                        key      <= '0;
                end else begin
                        case (state)
                        PK_CMD: if (xfer) begin
                                word_cnt <= '0;
                                blk_idx  <= '0;
                                // Bit 0 set: a fresh key follows
                                state    <= s00_axis_tdata[0] ? PK_KEY : PK_DATA;
                        end
                        PK_KEY: if (xfer) begin
                                key      <= {key[`AES_WORD_W*(`AES_NB-1)-1:0], s00_axis_tdata};
                                word_cnt <= word_cnt + 1'b1;
                                if (word_last) begin
                                        state <= PK_DATA;
                                end
                        end
                        PK_DATA: if (xfer) begin
                                word_cnt <= word_cnt + 1'b1;
                                if (word_last) begin
                                        blk_idx <= blk_idx + 1'b1;
                                        if (s00_axis_tlast) begin
                                                blk_cnt <= blk_idx + 1'b1;
                                                state   <= PK_END;
                                        end
                                end
                        end
                        default: state <= PK_CMD;
                        endcase
                end
        end

endmodule

/* verilog/add_round_key_engine.sv */
`timescale 1ns/10ps

module add_round_key_engine (
        input  logic                       s00_axis_aclk,
        input  logic                       rst_n,
        input  logic                       eng_start,
        input  aes_stream_pkg::blk_cnt_t   blk_cnt,
        input  aes_stream_pkg::block_t     key,
        output aes_stream_pkg::blk_addr_t  in_addr,
        output logic                       in_rd,
        input  aes_stream_pkg::block_t     in_data,
        output aes_stream_pkg::blk_addr_t  out_addr,
        output logic                       out_we,
        output aes_stream_pkg::block_t     out_data,
        output logic                       eng_done
);
        import aes_stream_pkg::*;

        typedef enum logic [1:0] {EN_IDLE, EN_READ, EN_WRITE, EN_DONE} en_state_t;

        en_state_t      state;
        blk_cnt_t       idx;

        // Same block index on both RAMs
        assign in_addr  = blk_addr_t'(idx);
        assign out_addr = blk_addr_t'(idx);

        assign in_rd    = (state == EN_READ);
        assign out_we   = (state == EN_WRITE);
        assign eng_done = (state == EN_DONE);

        // AddRoundKey on the registered RAM output
        assign out_data = in_data ^ key;

        // ============================================================
        // Read, then write, once per block
        // ============================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= EN_IDLE;
                        idx   <= '0;
                end else begin
                        case (state)
                        EN_IDLE: if (eng_start) begin
                                idx   <= '0;
                                state <= EN_READ;
                        end
                        // RAM output is valid in EN_WRITE
                        EN_READ: state <= EN_WRITE;
                        EN_WRITE: begin
                                idx <= idx + 1'b1;
                                if (idx + 1'b1 == blk_cnt) begin
                                        state <= EN_DONE;
                                end else begin
                                        state <= EN_READ;
                                end
                        end
                        default: state <= EN_IDLE;
                        endcase
                end
        end

endmodule

/* verilog/axis_block_unpacker.sv */
`timescale 1ns/10ps
`include "aes_stream_defs.svh"

module axis_block_unpacker (
        input  logic                       s00_axis_aclk,
        input  logic                       rst_n,
        input  logic                       tx_start,
        input  aes_stream_pkg::blk_cnt_t   blk_cnt,
        output aes_stream_pkg::blk_addr_t  ram_addr,
        input  aes_stream_pkg::block_t     ram_rdata,
        output aes_stream_pkg::word_t      m00_axis_tdata,
        output logic                       m00_axis_tvalid,
        output logic                       m00_axis_tlast,
        input  logic                       m00_axis_tready,
        output logic                       tx_done
);
        import aes_stream_pkg::*;

        typedef enum logic [1:0] {UP_IDLE, UP_PRIME, UP_LOAD, UP_SEND} up_state_t;

        up_state_t                      state;
        block_t                         blk;
        blk_cnt_t                       blk_idx;
        logic [$clog2(`AES_NB)-1:0]     word_cnt;
        logic                           xfer;
        logic                           word_last;
        logic                           blk_last;

        assign xfer      = m00_axis_tvalid && m00_axis_tready;
        assign word_last = (word_cnt == `AES_NB - 1);
        assign blk_last  = (blk_idx + 1'b1 == blk_cnt);

        // Most significant word goes out first
        assign m00_axis_tdata = blk[$bits(block_t)-1 -: `AES_WORD_W];
        assign m00_axis_tlast = m00_axis_tvalid && word_last && blk_last;

        // Output block, reloaded from the prefetched RAM word
        always_ff @(posedge s00_axis_aclk) begin
                if (state == UP_LOAD || (xfer && word_last)) begin
                        blk <= ram_rdata;
                end else if (xfer) begin
                        blk <= blk << `AES_WORD_W;
                end
        end

        // ============================================================
        // Master side sequencing
        // ============================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state           <= UP_IDLE;
                        ram_addr        <= '0;
                        blk_idx         <= '0;
                        word_cnt        <= '0;
                        m00_axis_tvalid <= 1'b0;
                        tx_done         <= 1'b0;
                end else begin
                        tx_done <= 1'b0;
                        case (state)
                        UP_IDLE: if (tx_start) begin
                                ram_addr <= '0;
                                state    <= UP_PRIME;
                        end
                        // Address 0 on the RAM, data shows up next cycle
                        UP_PRIME: state <= UP_LOAD;
                        UP_LOAD: begin
                                m00_axis_tvalid <= 1'b1;
                                // Start fetching block 1 while block 0 goes out
                                ram_addr        <= ram_addr + 1'b1;
                                blk_idx         <= '0;
                                word_cnt        <= '0;
                                state           <= UP_SEND;
                        end
                        UP_SEND: if (xfer) begin
                                word_cnt <= word_cnt + 1'b1;
                                if (word_last) begin
                                        blk_idx  <= blk_idx + 1'b1;
                                        ram_addr <= ram_addr + 1'b1;
                                end
                                if (m00_axis_tlast) begin
                                        m00_axis_tvalid <= 1'b0;
                                        tx_done         <= 1'b1;
                                        state           <= UP_IDLE;
                                end
                        end
                        default: state <= UP_IDLE;
                        endcase
                end
        end

endmodule

/* verilog/aes_axi_stream.sv */
`timescale 1ns/10ps

module aes_axi_stream (
        input  logic                       s00_axis_aclk,
        input  logic                       rst_n,
        input  aes_stream_pkg::word_t      s00_axis_tdata,
        input  logic                       s00_axis_tvalid,
        input  logic                       s00_axis_tlast,
        output logic                       s00_axis_tready,
        output aes_stream_pkg::word_t      m00_axis_tdata,
        output logic                       m00_axis_tvalid,
        output logic                       m00_axis_tlast,
        input  logic                       m00_axis_tready
);
        import aes_stream_pkg::*;

        ctrl_state_t    state;
        logic           rx_en;
        logic           rx_done;
        logic           eng_start;
        logic           eng_done;
        logic           tx_start;
        logic           tx_done;

        // Input RAM side
        blk_addr_t      pk_addr;
        block_t         pk_wdata;
        logic           pk_we;
        blk_addr_t      eng_in_addr;
        logic           eng_in_rd;
        blk_addr_t      in_addr;
        block_t         in_rdata;

        // Output RAM side
        blk_addr_t      eng_out_addr;
        logic           eng_out_we;
        block_t         eng_out_data;
        blk_addr_t      up_addr;
        blk_addr_t      out_addr;
        block_t         out_rdata;

        block_t         key;
        blk_cnt_t       blk_cnt;

        // ============================================================
        // Control FSM
        // ============================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= CTRL_IDLE;
                end else begin
                        case (state)
                        CTRL_IDLE:
                                if (s00_axis_tvalid)
                                        state <= CTRL_RECEIVE;
                        CTRL_RECEIVE:
                                if (rx_done)
                                        state <= CTRL_PROCESS;
                        CTRL_PROCESS:
                                if (eng_done)
                                        state <= CTRL_SEND;
                        default:
                                if (tx_done)
                                        state <= CTRL_IDLE;
                        endcase
                end
        end

        assign rx_en     = (state == CTRL_RECEIVE);
        assign eng_start = (state == CTRL_RECEIVE) && rx_done;
        assign tx_start  = (state == CTRL_PROCESS) && eng_done;

        // Engine owns a RAM port only while it uses it
        assign in_addr  = eng_in_rd ? eng_in_addr : pk_addr;
        assign out_addr = eng_out_we ? eng_out_addr : up_addr;

        // ============================================================
        // Stages and RAMs
        // ============================================================
        axis_block_packer packer (
                .s00_axis_aclk, .rst_n, .rx_en,
                .s00_axis_tdata, .s00_axis_tvalid, .s00_axis_tlast, .s00_axis_tready,
                .ram_addr(pk_addr), .ram_wdata(pk_wdata), .ram_we(pk_we),
                .key, .blk_cnt, .rx_done
        );

        block_ram in_ram (
                .s00_axis_aclk, .addr(in_addr), .wdata(pk_wdata), .we(pk_we),
                .rdata(in_rdata)
        );

        add_round_key_engine engine (
                .s00_axis_aclk, .rst_n, .eng_start, .blk_cnt, .key,
                .in_addr(eng_in_addr), .in_rd(eng_in_rd), .in_data(in_rdata),
                .out_addr(eng_out_addr), .out_we(eng_out_we), .out_data(eng_out_data),
                .eng_done
        );

        block_ram out_ram (
                .s00_axis_aclk, .addr(out_addr), .wdata(eng_out_data), .we(eng_out_we),
                .rdata(out_rdata)
        );

        axis_block_unpacker unpacker (
                .s00_axis_aclk, .rst_n, .tx_start, .blk_cnt,
                .ram_addr(up_addr), .ram_rdata(out_rdata),
                .m00_axis_tdata, .m00_axis_tvalid, .m00_axis_tlast, .m00_axis_tready,
                .tx_done
        );

endmodule

/* test/aes_axi_stream_sva.sv */
`timescale 1ns/10ps

module aes_axi_stream_sva (
        input  logic                       s00_axis_aclk,
        input  logic                       rst_n,
        input  logic                       s00_axis_tvalid,
        input  logic                       s00_axis_tready,
        input  aes_stream_pkg::word_t      m00_axis_tdata,
        input  logic                       m00_axis_tvalid,
        input  logic                       m00_axis_tready
);

        // ============================================================
        // Master stream rules
        // ============================================================

        // Stalled word stays put
        a_hold: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                m00_axis_tvalid && !m00_axis_tready |=>
                        m00_axis_tvalid && $stable(m00_axis_tdata))
                else $error("m00 stream changed while tready was low");

        // Both valids known once out of reset
        a_known: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                !$isunknown(s00_axis_tvalid) && !$isunknown(m00_axis_tvalid))
                else $error("tvalid is unknown");

        // No input while output is pending
        a_no_overlap: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                m00_axis_tvalid |-> !s00_axis_tready)
                else $error("s00_axis_tready high while m00_axis_tvalid is high");

endmodule

bind aes_axi_stream aes_axi_stream_sva sva (
        .s00_axis_aclk(s00_axis_aclk),
        .rst_n(rst_n),
        .s00_axis_tvalid(s00_axis_tvalid),
        .s00_axis_tready(s00_axis_tready),
        .m00_axis_tdata(m00_axis_tdata),
        .m00_axis_tvalid(m00_axis_tvalid),
        .m00_axis_tready(m00_axis_tready)
);

/* test/aes_axi_stream_tb.sv */
`timescale 1ns/10ps
`include "aes_stream_defs.svh"

module aes_axi_stream_tb;
        import aes_stream_pkg::*;

        localparam int NUM_FRAMES      = 6;
        localparam int RESET_CYCLES    = 10;
        localparam int WATCHDOG_CYCLES = RESET_CYCLES + 400 * NUM_FRAMES;

        // One row of the frame table
        typedef struct packed {
                logic           new_key;
                blk_cnt_t       nblk;
                word_t          key_seed;
                logic           bp;
        } frame_t;

        logic           s00_axis_aclk = 1'b0;
        logic           rst_n;
        word_t          s00_axis_tdata;
        logic           s00_axis_tvalid;
        logic           s00_axis_tlast;
        logic           s00_axis_tready;
        word_t          m00_axis_tdata;
        logic           m00_axis_tvalid;
        logic           m00_axis_tlast;
        logic           m00_axis_tready;

        // Columns: new key, blocks, key seed, output back-pressure
        frame_t frames [NUM_FRAMES] = '{
                '{1'b0, blk_cnt_t'(1), 32'h0000_0000, 1'b0},
                '{1'b1, blk_cnt_t'(2), 32'h5a5a_0f0f, 1'b0},
                '{1'b0, blk_cnt_t'(3), 32'h0000_0000, 1'b1},
                '{1'b1, blk_cnt_t'(`AES_FIFO_BLOCKS), 32'hc3c3_1234, 1'b1},
                '{1'b0, blk_cnt_t'(1), 32'h0000_0000, 1'b1},
                '{1'b1, blk_cnt_t'(`AES_FIFO_BLOCKS), 32'h0bad_cafe, 1'b0}
        };

        // Reference key, one word per block position
        word_t          key_words [`AES_NB] = '{default: '0};
        word_t          expected [$];
        word_t          lcg_state = 32'd7200;

        aes_axi_stream UUT (
                .s00_axis_aclk, .rst_n,
                .s00_axis_tdata, .s00_axis_tvalid, .s00_axis_tlast, .s00_axis_tready,
                .m00_axis_tdata, .m00_axis_tvalid, .m00_axis_tlast, .m00_axis_tready
        );

        always #2 s00_axis_aclk = ~s00_axis_aclk;

        function automatic word_t lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        // ============================================================
        // Checkers
        // ============================================================
        task automatic check_word(input word_t got, input word_t exp, input string what);
                if (got !== exp) begin
                        $display("ERR t=%0t: %s is %h, expected %h", $time, what, got, exp);
                        $display("TEST FAILED");
                        $fatal(1, "data mismatch");
                end
        endtask

        task automatic check_last(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("ERR t=%0t: %s tlast is %b, expected %b", $time, what, got, exp);
                        $display("TEST FAILED");
                        $fatal(1, "tlast mismatch");
                end
        endtask

        task automatic check_flag(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("ERR t=%0t: %s is %b, expected %b", $time, what, got, exp);
                        $display("TEST FAILED");
                        $fatal(1, "control flag mismatch");
                end
        endtask

        // ============================================================
        // Stream drivers, called and returning on a falling edge
        // ============================================================
        task automatic send_word(input word_t data, input logic last);
                s00_axis_tdata  = data;
                s00_axis_tlast  = last;
                s00_axis_tvalid = 1'b1;
                while (!s00_axis_tready) begin
                        @(negedge s00_axis_aclk);
                end
                // Transfer happens on the rising edge in between
                @(negedge s00_axis_aclk);
        endtask

        task automatic collect_frame(input int nwords, input logic bp);
                int     got_cnt;
                word_t  r;
                word_t  exp_word;
                got_cnt = 0;
                while (got_cnt < nwords) begin
                        r = lcg_next();
                        m00_axis_tready = bp ? (r[31:30] != 2'b00) : 1'b1;
                        check_flag(s00_axis_tready, 1'b0, "s00_axis_tready before output end");
                        if (m00_axis_tvalid && m00_axis_tready) begin
                                exp_word = expected.pop_front();
                                check_word(m00_axis_tdata, exp_word, "output word");
                                check_last(m00_axis_tlast, got_cnt == nwords - 1, "output word");
                                got_cnt++;
                        end
                        @(negedge s00_axis_aclk);
                end
                m00_axis_tready = 1'b0;
                // No extra word after the last one
                check_flag(m00_axis_tvalid, 1'b0, "m00_axis_tvalid after tlast");
                check_flag(s00_axis_tready, 1'b0, "s00_axis_tready after tlast");
        endtask

        task automatic run_frame(input frame_t f);
                word_t  cmd;
                word_t  w;
                int     b;
                int     k;
                cmd    = lcg_next();
                cmd[0] = f.new_key;
                send_word(cmd, 1'b0);
                if (f.new_key) begin
                        for (k = 0; k < `AES_NB; k++) begin
                                w            = lcg_next() ^ f.key_seed;
                                key_words[k] = w;
                                send_word(w, 1'b0);
                        end
                end
                for (b = 0; b < int'(f.nblk); b++) begin
                        for (k = 0; k < `AES_NB; k++) begin
                                w = lcg_next();
                                expected.push_back(w ^ key_words[k]);
                                send_word(w, (b == int'(f.nblk) - 1) && (k == `AES_NB - 1));
                        end
                end
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast  = 1'b0;
                collect_frame(int'(f.nblk) * `AES_NB, f.bp);
        endtask

        // ============================================================
        // Main sequence
        // ============================================================
        initial begin : main_seq
                int i;
                rst_n           = 1'b0;
                s00_axis_tdata  = '0;
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast  = 1'b0;
                m00_axis_tready = 1'b0;
                repeat (RESET_CYCLES) begin
                        @(negedge s00_axis_aclk);
                        check_flag(s00_axis_tready, 1'b0, "s00_axis_tready in reset");
                        check_flag(m00_axis_tvalid, 1'b0, "m00_axis_tvalid in reset");
                        check_flag(m00_axis_tlast, 1'b0, "m00_axis_tlast in reset");
                end
                rst_n = 1'b1;
                @(negedge s00_axis_aclk);
                check_flag(s00_axis_tready, 1'b0, "s00_axis_tready after reset");
                check_flag(m00_axis_tvalid, 1'b0, "m00_axis_tvalid after reset");
                check_flag(m00_axis_tlast, 1'b0, "m00_axis_tlast after reset");
                for (i = 0; i < NUM_FRAMES; i++) begin
                        run_frame(frames[i]);
                end
                $display("TEST PASSED");
                $finish;
        end

        // Generous bound per frame, plus reset
        initial begin : watchdog
                repeat (WATCHDOG_CYCLES) @(posedge s00_axis_aclk);
                $display("Timeout: the run did not finish within %0d clock cycles",
                         WATCHDOG_CYCLES);
                $display("TEST FAILED");
                $fatal(1, "watchdog expired");
        end

endmodule

/* vlog.f */
+incdir+verilog
verilog/aes_stream_pkg.sv
verilog/block_ram.sv
verilog/axis_block_packer.sv
verilog/add_round_key_engine.sv
verilog/axis_block_unpacker.sv
verilog/aes_axi_stream.sv
test/aes_axi_stream_sva.sv
test/aes_axi_stream_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build the testbench with Verilator, run it, and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aes_axi_stream_tb -f vlog.f \
        || { echo "Build failed"; exit 1; }

./obj_dir/Vaes_axi_stream_tb | tee /dev/stderr | grep -q "^TEST PASSED$" \
        && { echo "Simulation passed"; exit 0; } \
        || { echo "Simulation failed"; exit 1; }
